//--- source/npu_pkg.sv
`default_nettype none

package npu_pkg;

    localparam int bank_count = 4;
    localparam int bank_depth = 256;
    localparam int inst_depth = 64;

    typedef logic signed [15:0] word_t;
    typedef logic [7:0]         bank_addr_t;
    typedef logic [1:0]         bank_sel_t;
    typedef logic [5:0]         inst_addr_t;
    typedef logic [7:0]         elem_count_t;
    typedef logic [47:0]        inst_t;

    // --------------------------------------------------
    // instruction fields, low bit of each, from the top
    // --------------------------------------------------
    localparam int op_lsb        = 44;
    localparam int src1_bank_lsb = 42;
    localparam int src1_off_lsb  = 34;
    localparam int src2_bank_lsb = 32;
    localparam int src2_off_lsb  = 24;
    localparam int dest_bank_lsb = 22;
    localparam int dest_off_lsb  = 14;
    localparam int count_lsb     = 6;
    // bits 5:0 unused

    typedef enum logic [3:0] {
        op_halt = 4'd0,
        op_add  = 4'd1,
        op_relu = 4'd10
    } opcode_t;

    // who drives each bank
    typedef enum logic [2:0] {
        own_host,
        own_add_src1,
        own_add_src2,
        own_add_dest,
        own_relu_src,
        own_relu_dest
    } bank_owner_t;

endpackage

`default_nettype wire

//--- source/data_banks.sv
`timescale 1ns/100ps
`default_nettype none

module data_banks (
    input  wire                      CLOCK_50,
    input  wire npu_pkg::bank_addr_t bank_addr    [npu_pkg::bank_count],
    input  wire                      bank_wr_en   [npu_pkg::bank_count],
    input  wire npu_pkg::word_t      bank_wr_data [npu_pkg::bank_count],
    output npu_pkg::word_t           bank_rd_data [npu_pkg::bank_count]
);
    import npu_pkg::*;

    genvar b;
    generate
        for (b = 0; b < bank_count; b++) begin : g_bank
            word_t mem [bank_depth];

            // single port, read returns the old word on a write
            always_ff @(posedge CLOCK_50) begin
                bank_rd_data[b] <= mem[bank_addr[b]];
                if (bank_wr_en[b]) begin
                    mem[bank_addr[b]] <= bank_wr_data[b];
                end
            end
        end
    endgenerate

endmodule

`default_nettype wire

//--- source/bank_crossbar.sv
`timescale 1ns/100ps
`default_nettype none

module bank_crossbar (
    input  wire                         CLOCK_50,
    input  wire npu_pkg::bank_owner_t   bank_owner [npu_pkg::bank_count],
    input  wire npu_pkg::bank_sel_t     host_bank,
    input  wire npu_pkg::bank_addr_t    host_addr,
    input  wire                         host_wr_en,
    input  wire npu_pkg::word_t         host_wr_data,
    input  wire npu_pkg::bank_addr_t    add_src1_addr,
    input  wire npu_pkg::bank_addr_t    add_src2_addr,
    input  wire npu_pkg::bank_addr_t    add_dest_addr,
    input  wire npu_pkg::word_t         add_dest_wr_data,
    input  wire                         add_dest_wr_en,
    input  wire npu_pkg::bank_addr_t    relu_src_addr,
    input  wire npu_pkg::bank_addr_t    relu_dest_addr,
    input  wire npu_pkg::word_t         relu_dest_wr_data,
    input  wire                         relu_dest_wr_en,
    input  wire npu_pkg::word_t         bank_rd_data [npu_pkg::bank_count],
    output npu_pkg::word_t              host_rd_data,
    output npu_pkg::word_t              add_src1_data,
    output npu_pkg::word_t              add_src2_data,
    output npu_pkg::word_t              relu_src_data,
    output npu_pkg::bank_addr_t         bank_addr    [npu_pkg::bank_count],
    output npu_pkg::word_t              bank_wr_data [npu_pkg::bank_count],
    output logic                        bank_wr_en   [npu_pkg::bank_count]
);
    import npu_pkg::*;

    bank_sel_t host_bank_q;

    // host read data follows the address by one cycle
    always_ff @(posedge CLOCK_50) begin
        host_bank_q <= host_bank;
    end

    assign host_rd_data = bank_rd_data[host_bank_q];

    // per-bank request mux
    always_comb begin
        for (int b = 0; b < bank_count; b++) begin
            bank_addr[b]    = host_addr;
            bank_wr_data[b] = host_wr_data;
            bank_wr_en[b]   = host_wr_en && (host_bank == bank_sel_t'(b));
            case (bank_owner[b])
                own_add_src1: begin
                    bank_addr[b]  = add_src1_addr;
                    bank_wr_en[b] = 1'b0;
                end
                own_add_src2: begin
                    bank_addr[b]  = add_src2_addr;
                    bank_wr_en[b] = 1'b0;
                end
                own_add_dest: begin
                    bank_addr[b]    = add_dest_addr;
                    bank_wr_data[b] = add_dest_wr_data;
                    bank_wr_en[b]   = add_dest_wr_en;
                end
                own_relu_src: begin
                    bank_addr[b]  = relu_src_addr;
                    bank_wr_en[b] = 1'b0;
                end
                own_relu_dest: begin
                    bank_addr[b]    = relu_dest_addr;
                    bank_wr_data[b] = relu_dest_wr_data;
                    bank_wr_en[b]   = relu_dest_wr_en;
                end
                default: begin
                end
            endcase
        end
    end

    // read data back to whichever unit owns the bank
    always_comb begin
        add_src1_data = '0;
        add_src2_data = '0;
        relu_src_data = '0;
        for (int b = 0; b < bank_count; b++) begin
            if (bank_owner[b] == own_add_src1) begin
                add_src1_data = bank_rd_data[b];
            end
            if (bank_owner[b] == own_add_src2) begin
                add_src2_data = bank_rd_data[b];
            end
            if (bank_owner[b] == own_relu_src) begin
                relu_src_data = bank_rd_data[b];
            end
        end
    end

endmodule

`default_nettype wire

//--- source/matrix_add.sv
`timescale 1ns/100ps
`default_nettype none

module matrix_add (
    input  wire                       CLOCK_50,
    input  wire                       reset,
    input  wire                       start,
    input  wire npu_pkg::bank_addr_t  src1_addr,
    input  wire npu_pkg::bank_addr_t  src2_addr,
    input  wire npu_pkg::bank_addr_t  dest_addr,
    input  wire npu_pkg::elem_count_t count,
    input  wire npu_pkg::word_t       src1_data,
    input  wire npu_pkg::word_t       src2_data,
    output npu_pkg::bank_addr_t       src1_rd_addr,
    output npu_pkg::bank_addr_t       src2_rd_addr,
    output npu_pkg::bank_addr_t       dest_wr_addr,
    output npu_pkg::word_t            dest_wr_data,
    output logic                      dest_wr_en,
    output logic                      done
);
    import npu_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_stream,
        st_drain
    } state_t;

    state_t      state;
    elem_count_t remain;

    always_ff @(posedge CLOCK_50) begin
        if (reset) begin
            state      <= st_idle;
            dest_wr_en <= 1'b0;
            done       <= 1'b0;
        end else begin
            dest_wr_en <= (state == st_stream);
            case (state)
                st_idle: begin
                    if (start) begin
                        state <= st_stream;
                        done  <= 1'b0;
                    end
                end
                st_stream: begin
                    if (remain == elem_count_t'(1)) begin
                        state <= st_drain;
                    end
                end
                default: begin
                    // last write lands this cycle
                    state <= st_idle;
                    done  <= 1'b1;
                end
            endcase
        end
    end

    // offsets wrap at the end of the bank
    always_ff @(posedge CLOCK_50) begin
        if (start && state == st_idle) begin
            src1_rd_addr <= src1_addr;
            src2_rd_addr <= src2_addr;
            dest_wr_addr <= dest_addr;
            remain       <= count;
        end else begin
            if (state == st_stream) begin
                src1_rd_addr <= src1_rd_addr + 1'b1;
                src2_rd_addr <= src2_rd_addr + 1'b1;
                remain       <= remain - 1'b1;
            end
            if (dest_wr_en) begin
                dest_wr_addr <= dest_wr_addr + 1'b1;
            end
        end
    end

    assign dest_wr_data = src1_data + src2_data;

endmodule

`default_nettype wire

//--- source/matrix_relu.sv
`timescale 1ns/100ps
`default_nettype none

module matrix_relu (
    input  wire                       CLOCK_50,
    input  wire                       reset,
    input  wire                       start,
    input  wire npu_pkg::bank_addr_t  src_addr,
    input  wire npu_pkg::bank_addr_t  dest_addr,
    input  wire npu_pkg::elem_count_t count,
    input  wire npu_pkg::word_t       src_data,
    output npu_pkg::bank_addr_t       src_rd_addr,
    output npu_pkg::bank_addr_t       dest_wr_addr,
    output npu_pkg::word_t            dest_wr_data,
    output logic                      dest_wr_en,
    output logic                      done
);
    import npu_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_stream,
        st_drain
    } state_t;

    state_t      state;
    elem_count_t remain;

    always_ff @(posedge CLOCK_50) begin
        if (reset) begin
            state      <= st_idle;
            dest_wr_en <= 1'b0;
            done       <= 1'b0;
        end else begin
            dest_wr_en <= (state == st_stream);
            case (state)
                st_idle: begin
                    if (start) begin
                        state <= st_stream;
                        done  <= 1'b0;
                    end
                end
                st_stream: begin
                    if (remain == elem_count_t'(1)) begin
                        state <= st_drain;
                    end
                end
                default: begin
                    state <= st_idle;
                    done  <= 1'b1;
                end
            endcase
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (start && state == st_idle) begin
            src_rd_addr  <= src_addr;
            dest_wr_addr <= dest_addr;
            remain       <= count;
        end else begin
            if (state == st_stream) begin
                src_rd_addr <= src_rd_addr + 1'b1;
                remain      <= remain - 1'b1;
            end
            if (dest_wr_en) begin
                dest_wr_addr <= dest_wr_addr + 1'b1;
            end
        end
    end

    // negatives clamp to zero
    assign dest_wr_data = src_data[$bits(word_t)-1] ? word_t'(0) : src_data;

endmodule

`default_nettype wire

//--- source/inst_fetch.sv
`timescale 1ns/100ps
`default_nettype none

module inst_fetch (
    input  wire                      CLOCK_50,
    input  wire                      reset,
    input  wire                      run,
    input  wire                      take,
    input  wire                      inst_wr_en,
    input  wire npu_pkg::inst_addr_t inst_wr_addr,
    input  wire npu_pkg::inst_t      inst_wr_data,
    output npu_pkg::inst_t           fetch_inst,
    output logic                     fetch_valid
);
    import npu_pkg::*;

    inst_t      inst_mem [inst_depth];
    inst_addr_t pc;
    logic       fresh;

    // host load port and synchronous read at pc
    always_ff @(posedge CLOCK_50) begin
        if (inst_wr_en) begin
            inst_mem[inst_wr_addr] <= inst_wr_data;
        end
        fetch_inst <= inst_mem[pc];
    end

    // read register is stale for one cycle after pc moves or memory is written
    always_ff @(posedge CLOCK_50) begin
        if (reset) begin
            pc    <= '0;
            fresh <= 1'b0;
        end else begin
            if (take) begin
                pc <= pc + 1'b1;
            end
            fresh <= !take && !inst_wr_en;
        end
    end

    // a halt word parks the pc
    assign fetch_valid = fresh && run
                      && (opcode_t'(fetch_inst[op_lsb +: $bits(opcode_t)]) != op_halt);

endmodule

`default_nettype wire

//--- source/inst_dispatch.sv
`timescale 1ns/100ps
`default_nettype none

module inst_dispatch (
    input  wire                   CLOCK_50,
    input  wire                   reset,
    input  wire npu_pkg::inst_t   fetch_inst,
    input  wire                   fetch_valid,
    input  wire                   add_done,
    input  wire                   relu_done,
    output logic                  take,
    output logic                  busy,
    output logic                  retire,
    output npu_pkg::opcode_t      retire_op,
    output npu_pkg::bank_owner_t  bank_owner [npu_pkg::bank_count],
    output logic                  add_start,
    output logic                  relu_start,
    output npu_pkg::bank_addr_t   src1_addr,
    output npu_pkg::bank_addr_t   src2_addr,
    output npu_pkg::bank_addr_t   dest_addr,
    output npu_pkg::elem_count_t  count
);
    import npu_pkg::*;

    opcode_t     fetch_op;
    logic        known_op;
    logic        dec_valid;
    opcode_t     dec_op;
    bank_sel_t   dec_src1_bank;
    bank_sel_t   dec_src2_bank;
    bank_sel_t   dec_dest_bank;
    bank_addr_t  dec_src1_off;
    bank_addr_t  dec_src2_off;
    bank_addr_t  dec_dest_off;
    elem_count_t dec_count;
    logic        iss_valid;
    opcode_t     iss_op;
    logic        add_done_q;
    logic        relu_done_q;
    logic        done_rise;

    assign fetch_op = opcode_t'(fetch_inst[op_lsb +: $bits(opcode_t)]);
    assign known_op = (fetch_op == op_add) || (fetch_op == op_relu);

    // one instruction in flight, unknown opcodes are skipped
    assign take = fetch_valid && !busy;

    // --------------------------------------------------
    // decode
    // --------------------------------------------------
    always_ff @(posedge CLOCK_50) begin
        if (reset) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= take && known_op;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (take) begin
            dec_op        <= fetch_op;
            dec_src1_bank <= fetch_inst[src1_bank_lsb +: $bits(bank_sel_t)];
            dec_src2_bank <= fetch_inst[src2_bank_lsb +: $bits(bank_sel_t)];
            dec_dest_bank <= fetch_inst[dest_bank_lsb +: $bits(bank_sel_t)];
            dec_src1_off  <= fetch_inst[src1_off_lsb +: $bits(bank_addr_t)];
            dec_src2_off  <= fetch_inst[src2_off_lsb +: $bits(bank_addr_t)];
            dec_dest_off  <= fetch_inst[dest_off_lsb +: $bits(bank_addr_t)];
            dec_count     <= fetch_inst[count_lsb +: $bits(elem_count_t)];
        end
    end

    // --------------------------------------------------
    // issue, fills the owner table
    // --------------------------------------------------
    always_ff @(posedge CLOCK_50) begin
        if (reset) begin
            iss_valid <= 1'b0;
            for (int b = 0; b < bank_count; b++) begin
                bank_owner[b] <= own_host;
            end
        end else begin
            iss_valid <= dec_valid;
            if (done_rise) begin
                for (int b = 0; b < bank_count; b++) begin
                    bank_owner[b] <= own_host;
                end
            end
            if (dec_valid) begin
                if (dec_op == op_add) begin
                    bank_owner[dec_src1_bank] <= own_add_src1;
                    bank_owner[dec_src2_bank] <= own_add_src2;
                    bank_owner[dec_dest_bank] <= own_add_dest;
                end else begin
                    bank_owner[dec_src1_bank] <= own_relu_src;
                    bank_owner[dec_dest_bank] <= own_relu_dest;
                end
            end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (dec_valid) begin
            iss_op    <= dec_op;
            src1_addr <= dec_src1_off;
            src2_addr <= dec_src2_off;
            dest_addr <= dec_dest_off;
            count     <= dec_count;
        end
    end

    // --------------------------------------------------
    // execute strobes
    // --------------------------------------------------
    always_ff @(posedge CLOCK_50) begin
        if (reset) begin
            add_start  <= 1'b0;
            relu_start <= 1'b0;
        end else begin
            add_start  <= iss_valid && (iss_op == op_add);
            relu_start <= iss_valid && (iss_op == op_relu);
        end
    end

    // --------------------------------------------------
    // commit
    // --------------------------------------------------
    assign done_rise = (add_done && !add_done_q) || (relu_done && !relu_done_q);

    always_ff @(posedge CLOCK_50) begin
        if (reset) begin
            add_done_q  <= 1'b0;
            relu_done_q <= 1'b0;
            retire      <= 1'b0;
            busy        <= 1'b0;
        end else begin
            add_done_q  <= add_done;
            relu_done_q <= relu_done;
            retire      <= done_rise;
            if (take && known_op) begin
                busy <= 1'b1;
            end else if (done_rise) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (done_rise) begin
            retire_op <= iss_op;
        end
    end

endmodule

`default_nettype wire

//--- source/npu_top.sv
`timescale 1ns/100ps
`default_nettype none

module npu_top (
    input  wire                  CLOCK_50,
    input  wire                  reset,
    input  wire                  run,
    input  wire                  inst_wr_en,
    input  wire npu_pkg::inst_addr_t inst_wr_addr,
    input  wire npu_pkg::inst_t  inst_wr_data,
    input  wire npu_pkg::bank_sel_t  host_bank,
    input  wire npu_pkg::bank_addr_t host_addr,
    input  wire                  host_wr_en,
    input  wire npu_pkg::word_t  host_wr_data,
    output npu_pkg::word_t       host_rd_data,
    output logic                 busy,
    output logic                 retire,
    output npu_pkg::opcode_t     retire_op
);
    import npu_pkg::*;

    inst_t       fetch_inst;
    logic        fetch_valid;
    logic        take;
    bank_owner_t bank_owner [bank_count];
    logic        add_start;
    logic        relu_start;
    logic        add_done;
    logic        relu_done;
    bank_addr_t  src1_addr;
    bank_addr_t  src2_addr;
    bank_addr_t  dest_addr;
    elem_count_t count;

    // unit side of the crossbar
    bank_addr_t  add_src1_addr;
    bank_addr_t  add_src2_addr;
    bank_addr_t  add_dest_addr;
    word_t       add_dest_wr_data;
    logic        add_dest_wr_en;
    word_t       add_src1_data;
    word_t       add_src2_data;
    bank_addr_t  relu_src_addr;
    bank_addr_t  relu_dest_addr;
    word_t       relu_dest_wr_data;
    logic        relu_dest_wr_en;
    word_t       relu_src_data;

    // bank side
    bank_addr_t  bank_addr    [bank_count];
    word_t       bank_wr_data [bank_count];
    logic        bank_wr_en   [bank_count];
    word_t       bank_rd_data [bank_count];

    inst_fetch u_fetch (
        .CLOCK_50     (CLOCK_50),
        .reset        (reset),
        .run          (run),
        .take         (take),
        .inst_wr_en   (inst_wr_en),
        .inst_wr_addr (inst_wr_addr),
        .inst_wr_data (inst_wr_data),
        .fetch_inst   (fetch_inst),
        .fetch_valid  (fetch_valid)
    );

    inst_dispatch u_dispatch (
        .CLOCK_50    (CLOCK_50),
        .reset       (reset),
        .fetch_inst  (fetch_inst),
        .fetch_valid (fetch_valid),
        .add_done    (add_done),
        .relu_done   (relu_done),
        .take        (take),
        .busy        (busy),
        .retire      (retire),
        .retire_op   (retire_op),
        .bank_owner  (bank_owner),
        .add_start   (add_start),
        .relu_start  (relu_start),
        .src1_addr   (src1_addr),
        .src2_addr   (src2_addr),
        .dest_addr   (dest_addr),
        .count       (count)
    );

    bank_crossbar u_xbar (
        .CLOCK_50          (CLOCK_50),
        .bank_owner        (bank_owner),
        .host_bank         (host_bank),
        .host_addr         (host_addr),
        .host_wr_en        (host_wr_en),
        .host_wr_data      (host_wr_data),
        .add_src1_addr     (add_src1_addr),
        .add_src2_addr     (add_src2_addr),
        .add_dest_addr     (add_dest_addr),
        .add_dest_wr_data  (add_dest_wr_data),
        .add_dest_wr_en    (add_dest_wr_en),
        .relu_src_addr     (relu_src_addr),
        .relu_dest_addr    (relu_dest_addr),
        .relu_dest_wr_data (relu_dest_wr_data),
        .relu_dest_wr_en   (relu_dest_wr_en),
        .bank_rd_data      (bank_rd_data),
        .host_rd_data      (host_rd_data),
        .add_src1_data     (add_src1_data),
        .add_src2_data     (add_src2_data),
        .relu_src_data     (relu_src_data),
        .bank_addr         (bank_addr),
        .bank_wr_data      (bank_wr_data),
        .bank_wr_en        (bank_wr_en)
    );

    data_banks u_banks (
        .CLOCK_50     (CLOCK_50),
        .bank_addr    (bank_addr),
        .bank_wr_en   (bank_wr_en),
        .bank_wr_data (bank_wr_data),
        .bank_rd_data (bank_rd_data)
    );

    matrix_add u_add (
        .CLOCK_50     (CLOCK_50),
        .reset        (reset),
        .start        (add_start),
        .src1_addr    (src1_addr),
        .src2_addr    (src2_addr),
        .dest_addr    (dest_addr),
        .count        (count),
        .src1_data    (add_src1_data),
        .src2_data    (add_src2_data),
        .src1_rd_addr (add_src1_addr),
        .src2_rd_addr (add_src2_addr),
        .dest_wr_addr (add_dest_addr),
        .dest_wr_data (add_dest_wr_data),
        .dest_wr_en   (add_dest_wr_en),
        .done         (add_done)
    );

    // relu reads through the src1 fields of the instruction
    matrix_relu u_relu (
        .CLOCK_50     (CLOCK_50),
        .reset        (reset),
        .start        (relu_start),
        .src_addr     (src1_addr),
        .dest_addr    (dest_addr),
        .count        (count),
        .src_data     (relu_src_data),
        .src_rd_addr  (relu_src_addr),
        .dest_wr_addr (relu_dest_addr),
        .dest_wr_data (relu_dest_wr_data),
        .dest_wr_en   (relu_dest_wr_en),
        .done         (relu_done)
    );

endmodule

`default_nettype wire

//--- verif/npu_tb_tasks.svh
`ifndef npu_tb_tasks_svh
`define npu_tb_tasks_svh

// --------------------------------------------------
// host port access
// --------------------------------------------------
task automatic host_write(input bank_sel_t b, input bank_addr_t a, input word_t d);
    @(posedge CLOCK_50);
    host_bank    <= b;
    host_addr    <= a;
    host_wr_data <= d;
    host_wr_en   <= 1'b1;
    @(posedge CLOCK_50);
    host_wr_en   <= 1'b0;
    model_mem[b][a] = d;
endtask

// data comes back one cycle after the address
task automatic host_read(input bank_sel_t b, input bank_addr_t a, output word_t d);
    @(posedge CLOCK_50);
    host_bank <= b;
    host_addr <= a;
    @(posedge CLOCK_50);
    @(negedge CLOCK_50);
    d = host_rd_data;
endtask

task automatic fill_banks();
    for (int b = 0; b < bank_count; b++) begin
        for (int a = 0; a < bank_depth; a++) begin
            host_write(bank_sel_t'(b), bank_addr_t'(a), word_t'($urandom));
        end
    end
endtask

task automatic compare_banks();
    word_t got;
    for (int b = 0; b < bank_count; b++) begin
        for (int a = 0; a < bank_depth; a++) begin
            host_read(bank_sel_t'(b), bank_addr_t'(a), got);
            assert (got == model_mem[b][a]) else begin
                $display("Mismatch at %0t: bank %0d word %0d read %h, model %h",
                         $time, b, a, got, model_mem[b][a]);
                errors++;
            end
        end
    end
endtask

// --------------------------------------------------
// reference model, one instruction at a time
// --------------------------------------------------
function automatic void apply_model(input inst_t inst);
    opcode_t    op;
    bank_sel_t  s1_bank;
    bank_sel_t  s2_bank;
    bank_sel_t  d_bank;
    bank_addr_t s1_off;
    bank_addr_t s2_off;
    bank_addr_t d_off;
    int         n;
    word_t      a;
    word_t      b;
    op      = opcode_t'(inst[47:44]);
    s1_bank = inst[43:42];
    s1_off  = inst[41:34];
    s2_bank = inst[33:32];
    s2_off  = inst[31:24];
    d_bank  = inst[23:22];
    d_off   = inst[21:14];
    n       = int'(inst[13:6]);
    for (int k = 0; k < n; k++) begin
        a = model_mem[s1_bank][s1_off];
        b = model_mem[s2_bank][s2_off];
        if (op == op_add) begin
            model_mem[d_bank][d_off] = a + b;
        end else begin
            model_mem[d_bank][d_off] = (a < word_t'(0)) ? word_t'(0) : a;
        end
        // offsets wrap at the bank end
        s1_off++;
        s2_off++;
        d_off++;
    end
endfunction

`endif

//--- verif/npu_tb.sv
`timescale 1ns/100ps
`default_nettype none

module npu_tb;
    import npu_pkg::*;

    localparam int rand_seed      = 4;
    localparam int timeout_cycles = 2000;
    localparam int quiet_cycles   = 20;
    localparam int mixed_length   = 10;

    logic       CLOCK_50;
    logic       reset;
    logic       run;
    logic       inst_wr_en;
    inst_addr_t inst_wr_addr;
    inst_t      inst_wr_data;
    bank_sel_t  host_bank;
    bank_addr_t host_addr;
    logic       host_wr_en;
    word_t      host_wr_data;
    word_t      host_rd_data;
    logic       busy;
    logic       retire;
    opcode_t    retire_op;

    word_t   model_mem [bank_count][bank_depth];
    inst_t   prog [$];
    opcode_t exp_ops [$];
    int      errors;
    int      test_errors;
    int      tests_run;
    int      tests_bad;

    npu_top dut_i (
        .CLOCK_50     (CLOCK_50),
        .reset        (reset),
        .run          (run),
        .inst_wr_en   (inst_wr_en),
        .inst_wr_addr (inst_wr_addr),
        .inst_wr_data (inst_wr_data),
        .host_bank    (host_bank),
        .host_addr    (host_addr),
        .host_wr_en   (host_wr_en),
        .host_wr_data (host_wr_data),
        .host_rd_data (host_rd_data),
        .busy         (busy),
        .retire       (retire),
        .retire_op    (retire_op)
    );

    initial begin
        CLOCK_50 = 1'b0;
    end

    always #2 CLOCK_50 = ~CLOCK_50;

    `include "npu_tb_tasks.svh"

    task automatic apply_reset();
        reset <= 1'b1;
        repeat (4) @(posedge CLOCK_50);
        reset <= 1'b0;
    endtask

    // three distinct banks per instruction
    function automatic void queue_inst(input opcode_t op);
        int    b1;
        int    o1;
        int    o2;
        inst_t inst;
        b1   = $urandom_range(0, 3);
        o1   = $urandom_range(1, 3);
        o2   = ((o1 + $urandom_range(0, 1)) % 3) + 1;
        inst = {op, bank_sel_t'(b1), bank_addr_t'($urandom),
                bank_sel_t'((b1 + o1) % 4), bank_addr_t'($urandom),
                bank_sel_t'((b1 + o2) % 4), bank_addr_t'($urandom),
                elem_count_t'($urandom_range(1, 64)), 6'd0};
        prog.push_back(inst);
        exp_ops.push_back(op);
        apply_model(inst);
    endfunction

    function automatic opcode_t random_op();
        return ($urandom_range(0, 1) == 0) ? op_add : op_relu;
    endfunction

    // trailing zero word halts fetch, reset brings pc back to zero
    task automatic load_program();
        @(posedge CLOCK_50);
        run <= 1'b0;
        for (int k = 0; k <= prog.size(); k++) begin
            @(posedge CLOCK_50);
            inst_wr_en   <= 1'b1;
            inst_wr_addr <= inst_addr_t'(k);
            if (k < prog.size()) begin
                inst_wr_data <= prog[k];
            end else begin
                inst_wr_data <= inst_t'(0);
            end
        end
        @(posedge CLOCK_50);
        inst_wr_en <= 1'b0;
        apply_reset();
    endtask

    task automatic run_program();
        int seen;
        int cycles;
        seen   = 0;
        cycles = 0;
        @(posedge CLOCK_50);
        run <= 1'b1;
        while (seen < exp_ops.size() && cycles < timeout_cycles) begin
            @(negedge CLOCK_50);
            cycles++;
            if (retire) begin
                assert (retire_op == exp_ops[seen]) else begin
                    $display("Mismatch at %0t: retire %0d has opcode %0d, program has %0d",
                             $time, seen, retire_op, exp_ops[seen]);
                    errors++;
                end
                seen++;
            end
        end
        assert (seen == exp_ops.size()) else begin
            $display("timeout at %0t: only %0d of %0d instructions retired",
                     $time, seen, exp_ops.size());
            errors++;
        end
        // parked on the halt word now
        cycles = 0;
        while (seen == exp_ops.size() && cycles < quiet_cycles) begin
            @(negedge CLOCK_50);
            cycles++;
            assert (!retire && !busy) else begin
                $display("busy or retire seen at %0t after the last instruction", $time);
                errors++;
            end
        end
        @(posedge CLOCK_50);
        run <= 1'b0;
    endtask

    // --------------------------------------------------
    // tests
    // --------------------------------------------------
    task automatic host_test();
        bank_sel_t  banks [16];
        bank_addr_t addrs [16];
        word_t      got;
        for (int k = 0; k < 16; k++) begin
            banks[k] = bank_sel_t'($urandom);
            addrs[k] = bank_addr_t'($urandom);
            host_write(banks[k], addrs[k], word_t'($urandom));
        end
        for (int k = 0; k < 16; k++) begin
            host_read(banks[k], addrs[k], got);
            assert (got == model_mem[banks[k]][addrs[k]]) else begin
                $display("Mismatch at %0t: host read bank %0d word %0d got %h, wrote %h",
                         $time, banks[k], addrs[k], got, model_mem[banks[k]][addrs[k]]);
                errors++;
            end
        end
    endtask

    task automatic program_test(input int length, input bit hold_run);
        int cycles;
        cycles = 0;
        for (int k = 0; k < length; k++) begin
            queue_inst(random_op());
        end
        load_program();
        while (hold_run && cycles < timeout_cycles) begin
            @(negedge CLOCK_50);
            cycles++;
            assert (!retire) else begin
                $display("retire at %0t while run was held low", $time);
                errors++;
            end
        end
        run_program();
        compare_banks();
    endtask

    task automatic single_test(input opcode_t op);
        queue_inst(op);
        load_program();
        run_program();
        compare_banks();
    endtask

    task automatic start_test();
        prog.delete();
        exp_ops.delete();
        test_errors = errors;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors > test_errors) begin
            tests_bad++;
            $display("test %0d %s: FAIL with %0d errors", tests_run, name, errors - test_errors);
        end else begin
            $display("test %0d %s: ok", tests_run, name);
        end
    endtask

    initial begin
        reset        <= 1'b1;
        run          <= 1'b0;
        inst_wr_en   <= 1'b0;
        inst_wr_addr <= '0;
        inst_wr_data <= '0;
        host_bank    <= '0;
        host_addr    <= '0;
        host_wr_en   <= 1'b0;
        host_wr_data <= '0;
        errors    = 0;
        tests_run = 0;
        tests_bad = 0;
        void'($urandom(rand_seed));
        apply_reset();

        start_test();
        host_test();
        finish_test("host write and read");

        start_test();
        fill_banks();
        single_test(op_add);
        finish_test("single add");

        start_test();
        single_test(op_relu);
        finish_test("single relu");

        start_test();
        program_test(mixed_length, 1'b0);
        finish_test("mixed program");

        start_test();
        program_test(4, 1'b1);
        finish_test("run held low");

        $display("summary: %0d tests run, %0d failing, %0d errors", tests_run, tests_bad, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+verif
source/npu_pkg.sv
source/data_banks.sv
source/bank_crossbar.sv
source/matrix_add.sv
source/matrix_relu.sv
source/inst_fetch.sv
source/inst_dispatch.sv
source/npu_top.sv
verif/npu_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the npu testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module npu_tb -f filelist.f -o npu_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/npu_sim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "all tests passed"; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1
